//--- analog_cfg/analog_cfg.sv
`default_nettype none

module analog_cfg
    import ising_pkg::*;
(
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                en_i,
    // timing configuration
    input  logic                cfg_load_i,
    input  cfg_timing_t         timing_i,
    input  logic                dt_cfg_start_i,
    // weight store read side
    output logic                j_ren_o,
    output logic [J_ADDR_W-1:0] j_raddr_o,
    input  j_word_t             j_rdata_i,
    output logic                h_ren_o,
    input  wbl_row_t            h_rdata_i,
    // analog macro
    output logic [NUM_SPIN-1:0] j_wwl_o,
    output logic                h_wwl_o,
    output wbl_row_t            wbl_o,
    output logic                cfg_idle_o
);

    cfg_state_e state_q, state_d;

    logic                 rd_valid_q;
    logic                 bypass_q;
    logic [ROW_SEL_W-1:0] sel_q;
    logic [ROW_SEL_W-1:0] sel_inc;
    logic [ROW_SEL_W-1:0] row_sel;
    logic [ROW_IDX_W-1:0] row_idx;
    logic [NUM_SPIN-1:0]  row_onehot;
    logic [CNT_W-1:0]     addr_cnt;
    logic [CNT_W-1:0]     addr_limit;
    logic                 h_phase;
    logic                 last_row;
    logic                 fetch_rd;
    logic                 high_ovf;
    logic                 low_ovf;
    logic                 addr_step;
    logic                 pass_done;
    logic                 cvt_load;
    wbl_row_t             cvt_row;

    // one extra count so the h row follows the last J word
    assign addr_limit = CNT_W'(timing_i.trans_num) + CNT_W'(1);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            bypass_q <= 1'b0;
        end else if (cfg_load_i) begin
            bypass_q <= timing_i.bypass;
        end
    end

    assign sel_inc   = sel_q + ROW_SEL_W'(1);
    assign last_row  = (sel_q == ROW_SEL_W'(PARALLELISM - 1));
    assign addr_step = low_ovf & (h_phase | last_row);

    // read strobe in the first FETCH cycle, data arrives in the second
    assign fetch_rd  = en_i & (state_q == CFG_FETCH) & ~rd_valid_q;
    assign j_ren_o   = fetch_rd & ~h_phase;
    assign h_ren_o   = fetch_rd & h_phase;
    assign j_raddr_o = addr_cnt[J_ADDR_W-1:0];

    // next row is loaded at the end of the low gap, ahead of its pulse
    assign row_sel  = (state_q == CFG_WWL_LOW) ? sel_inc : sel_q;
    assign cvt_row  = h_phase ? h_rdata_i : j_rdata_i[row_sel];
    assign cvt_load = (en_i & (state_q == CFG_FETCH) & rd_valid_q) | (low_ovf & ~addr_step);

    assign row_idx    = {addr_cnt[J_ADDR_W-1:0], sel_q};
    assign row_onehot = NUM_SPIN'(1) << row_idx;
    assign cfg_idle_o = (state_q == CFG_IDLE);

    always_comb begin
        state_d = state_q;
        case (state_q)
            CFG_IDLE: begin
                if (dt_cfg_start_i) begin
                    state_d = CFG_FETCH;
                end
            end
            CFG_FETCH: begin
                if (rd_valid_q) begin
                    state_d = CFG_NEXT;
                end
            end
            // wbl already holds the row, word line rises on the next edge
            CFG_NEXT: state_d = CFG_WWL_HIGH;
            CFG_WWL_HIGH: begin
                if (high_ovf) begin
                    state_d = CFG_WWL_LOW;
                end
            end
            CFG_WWL_LOW: begin
                if (pass_done) begin
                    state_d = CFG_IDLE;
                end else if (addr_step) begin
                    state_d = CFG_FETCH;
                end else if (low_ovf) begin
                    state_d = CFG_NEXT;
                end
            end
            default: state_d = CFG_IDLE;
        endcase
        if (!en_i) begin
            state_d = CFG_IDLE;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q    <= CFG_IDLE;
            rd_valid_q <= 1'b0;
        end else begin
            state_q    <= state_d;
            rd_valid_q <= j_ren_o | h_ren_o;
        end
    end

    // row select inside the current J word
    always_ff @(posedge clk_i) begin
        if (rst_i || !en_i || state_q == CFG_IDLE) begin
            sel_q <= '0;
        end else if (low_ovf) begin
            sel_q <= addr_step ? '0 : sel_inc;
        end
    end

    // word lines, high for exactly the WWL_HIGH state
    always_ff @(posedge clk_i) begin
        if (rst_i || !en_i) begin
            j_wwl_o <= '0;
            h_wwl_o <= 1'b0;
        end else if (state_q == CFG_NEXT) begin
            j_wwl_o <= h_phase ? '0 : row_onehot;
            h_wwl_o <= h_phase;
        end else if (high_ovf) begin
            j_wwl_o <= '0;
            h_wwl_o <= 1'b0;
        end
    end

    step_counter i_wwl_high_counter (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .en_i       (en_i),
        .load_i     (cfg_load_i),
        .recount_i  (cfg_idle_o),
        .step_i     (state_q == CFG_WWL_HIGH),
        .d_i        (timing_i.wwl_high),
        .q_o        (),
        .maxed_o    (),
        .overflow_o (high_ovf)
    );

    step_counter i_wwl_low_counter (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .en_i       (en_i),
        .load_i     (cfg_load_i),
        .recount_i  (cfg_idle_o),
        .step_i     (state_q == CFG_WWL_LOW),
        .d_i        (timing_i.wwl_low),
        .q_o        (),
        .maxed_o    (),
        .overflow_o (low_ovf)
    );

    // maxed marks the h row, the wrap after it ends the pass
    step_counter i_addr_counter (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .en_i       (en_i),
        .load_i     (cfg_load_i),
        .recount_i  (cfg_idle_o),
        .step_i     (addr_step),
        .d_i        (addr_limit),
        .q_o        (addr_cnt),
        .maxed_o    (h_phase),
        .overflow_o (pass_done)
    );

    wbl_converter i_wbl_converter (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .load_i   (cvt_load),
        .bypass_i (bypass_q),
        .row_i    (cvt_row),
        .wbl_o    (wbl_o)
    );

    j_wwl_onehot_a: assert property (
        @(posedge clk_i) disable iff (rst_i) $onehot0(j_wwl_o)
    ) else $error("more than one J word line high");

    wwl_exclusive_a: assert property (
        @(posedge clk_i) disable iff (rst_i) !((|j_wwl_o) && h_wwl_o)
    ) else $error("J and h word lines high together");

    idle_quiet_a: assert property (
        @(posedge clk_i) disable iff (rst_i)
        (state_q == CFG_IDLE) |-> (j_wwl_o == '0) && !h_wwl_o
    ) else $error("word line high while idle");

    // the converter must never be reloaded under an active pulse
    load_in_gap_a: assert property (
        @(posedge clk_i) disable iff (rst_i)
        cvt_load |-> (j_wwl_o == '0) && !h_wwl_o
    ) else $error("wbl reloaded while a word line is high");

endmodule

`default_nettype wire

//--- analog_cfg/wbl_converter.sv
`default_nettype none

module wbl_converter
    import ising_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_i,
    input  logic     load_i,
    input  logic     bypass_i,
    input  wbl_row_t row_i,
    output wbl_row_t wbl_o
);

    wbl_row_t row_cvt;

    // per-weight code conversion for the whole row
    always_comb begin
        for (int i = 0; i < NUM_SPIN; i++) begin
            row_cvt[i] = to_analog(row_i[i]);
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wbl_o <= '0;
        end else if (load_i) begin
            wbl_o <= bypass_i ? row_i : row_cvt;
        end
    end

    // a row is loaded once and then held through its pulse
    load_strobe_a: assert property (
        @(posedge clk_i) disable iff (rst_i)
        load_i |=> !load_i
    ) else $error("wbl loaded on two cycles in a row");

endmodule

`default_nettype wire

//--- bench/tb_ising_cfg.sv
`default_nettype none

module tb_ising_cfg
    import ising_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int START_TIMEOUT = 20;
    localparam int PASS_TIMEOUT  = 3000;
    localparam int ROW_TIMEOUT   = 500;

    logic                clk;
    logic                rst;
    logic                j_wr_en;
    logic [J_ADDR_W-1:0] j_waddr;
    j_word_t             j_wdata;
    logic                h_wr_en;
    wbl_row_t            h_wdata;
    logic                cfg_load;
    cfg_timing_t         timing;
    logic                en;
    logic                dt_cfg_start;
    logic [NUM_SPIN-1:0] j_wwl;
    logic                h_wwl;
    wbl_row_t            wbl;
    logic                cfg_idle;
    logic                wwl_any;

    // reference model of the store contents and the loaded timing
    wbl_row_t j_rows [NUM_SPIN];
    wbl_row_t h_row;
    int       exp_high;
    int       exp_low;
    int       n_rows;
    logic     exp_bypass;
    logic     monitor_on;

    int            pulse_cnt;
    int            high_len;
    int            low_len;
    logic [NUM_SPIN:0] exp_wwl;
    wbl_row_t      exp_wbl;
    int            error_count;
    int            test_count;

    ising_cfg_top i_dut (
        .clk_i          (clk),
        .rst_i          (rst),
        .j_wr_en_i      (j_wr_en),
        .j_waddr_i      (j_waddr),
        .j_wdata_i      (j_wdata),
        .h_wr_en_i      (h_wr_en),
        .h_wdata_i      (h_wdata),
        .cfg_load_i     (cfg_load),
        .timing_i       (timing),
        .en_i           (en),
        .dt_cfg_start_i (dt_cfg_start),
        .j_wwl_o        (j_wwl),
        .h_wwl_o        (h_wwl),
        .wbl_o          (wbl),
        .cfg_idle_o     (cfg_idle)
    );

    assign wwl_any = h_wwl | (|j_wwl);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // macro code: zero stays zero, else bit 0 is the inverted sign
    // and the upper bits are the magnitude modulo 8
    function automatic weight_t sign_mag_code(weight_t w);
        int value;
        int mag;
        weight_t code;
        value = int'(w);
        mag = (value < 0) ? -value : value;
        code = '0;
        if (value != 0) begin
            code = weight_t'({(BITDATA-1)'(mag % 8), value > 0});
        end
        return code;
    endfunction

    function automatic wbl_row_t expected_row(wbl_row_t raw, logic bypass);
        wbl_row_t row;
        row = raw;
        if (!bypass) begin
            for (int i = 0; i < NUM_SPIN; i++) begin
                row[i] = sign_mag_code(raw[i]);
            end
        end
        return row;
    endfunction

    function automatic wbl_row_t random_row();
        wbl_row_t row;
        for (int i = 0; i < NUM_SPIN; i++) begin
            row[i] = weight_t'($urandom_range(15, 0));
        end
        return row;
    endfunction

    // k-th pulse of a pass goes to J row k, the last one to the h row
    always_comb begin
        if (pulse_cnt < n_rows) begin
            exp_wwl = (NUM_SPIN+1)'(1) << pulse_cnt;
            exp_wbl = expected_row(j_rows[pulse_cnt[ROW_IDX_W-1:0]], exp_bypass);
        end else begin
            exp_wwl = (NUM_SPIN+1)'(1) << NUM_SPIN;
            exp_wbl = expected_row(h_row, exp_bypass);
        end
    end

    // pulse and gap lengths, in cycles seen at the rising edges
    always @(posedge clk) begin
        if (rst) begin
            pulse_cnt <= 0;
            high_len  <= 0;
            low_len   <= 0;
        end else begin
            high_len <= wwl_any ? high_len + 1 : 0;
            low_len  <= wwl_any ? 0 : low_len + 1;
            if (dt_cfg_start) begin
                pulse_cnt <= 0;
            end else if (!wwl_any && high_len != 0) begin
                pulse_cnt <= pulse_cnt + 1;
            end
        end
    end

    single_hot_a: assert property (@(posedge clk) disable iff (rst)
        $onehot0({h_wwl, j_wwl})
    ) else log_error("more than one word line high");

    idle_quiet_a: assert property (@(posedge clk) disable iff (rst)
        cfg_idle |-> !wwl_any
    ) else log_error("word line high while idle");

    row_order_a: assert property (@(posedge clk) disable iff (rst)
        monitor_on && wwl_any |-> {h_wwl, j_wwl} == exp_wwl
    ) else log_error("word line out of order");

    row_data_a: assert property (@(posedge clk) disable iff (rst)
        monitor_on && wwl_any |-> wbl == exp_wbl
    ) else log_error("wbl does not match the stored row");

    wbl_setup_a: assert property (@(posedge clk) disable iff (rst)
        monitor_on && $rose(wwl_any) |-> $stable(wbl)
    ) else log_error("wbl changed at the rising word line edge");

    wbl_hold_a: assert property (@(posedge clk) disable iff (rst)
        monitor_on && $fell(wwl_any) |-> $stable(wbl)
    ) else log_error("wbl changed at the falling word line edge");

    pulse_width_a: assert property (@(posedge clk) disable iff (rst)
        monitor_on && $fell(wwl_any) |-> high_len == exp_high
    ) else log_error("word line pulse width wrong");

    gap_width_a: assert property (@(posedge clk) disable iff (rst)
        monitor_on && $rose(wwl_any) && pulse_cnt != 0 |-> low_len >= exp_low
    ) else log_error("low gap between pulses too short");

    pass_count_a: assert property (@(posedge clk) disable iff (rst)
        monitor_on && $rose(cfg_idle) |-> pulse_cnt == n_rows + 1
    ) else log_error("wrong number of pulses in a pass");

    final_gap_a: assert property (@(posedge clk) disable iff (rst)
        monitor_on && $rose(cfg_idle) |-> low_len >= exp_low
    ) else log_error("idle before the final low gap ended");

    task automatic log_error(string msg);
        error_count++;
        $display("[ERROR] %0t ns: %s", $time, msg);
    endtask

    task automatic report_timeout(string what);
        $display("timeout while waiting for %s", what);
        $display("Test failed");
        $finish;
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic finish_test(string name, int errs_before);
        test_count++;
        if (error_count == errs_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, error_count - errs_before);
        end
    endtask

    task automatic load_timing(int high, int low, int trans, logic bypass);
        next_cycle();
        timing.wwl_high  = CNT_W'(high);
        timing.wwl_low   = CNT_W'(low);
        timing.trans_num = (J_ADDR_W+1)'(trans);
        timing.bypass    = bypass;
        cfg_load         = 1'b1;
        exp_high   = high;
        exp_low    = low;
        n_rows     = trans * PARALLELISM;
        exp_bypass = bypass;
        next_cycle();
        cfg_load = 1'b0;
    endtask

    task automatic write_store();
        for (int a = 0; a < J_DEPTH; a++) begin
            next_cycle();
            j_wr_en = 1'b1;
            j_waddr = J_ADDR_W'(a);
            for (int r = 0; r < PARALLELISM; r++) begin
                j_wdata[r] = j_rows[a * PARALLELISM + r];
            end
        end
        next_cycle();
        j_wr_en = 1'b0;
        h_wr_en = 1'b1;
        h_wdata = h_row;
        next_cycle();
        h_wr_en = 1'b0;
    endtask

    task automatic run_pass(string what);
        int cycles;
        next_cycle();
        dt_cfg_start = 1'b1;
        next_cycle();
        dt_cfg_start = 1'b0;
        cycles = 0;
        while (cfg_idle) begin
            if (cycles >= START_TIMEOUT) report_timeout({what, " to leave idle"});
            next_cycle();
            cycles++;
        end
        cycles = 0;
        while (!cfg_idle) begin
            if (cycles >= PASS_TIMEOUT) report_timeout({what, " to return to idle"});
            next_cycle();
            cycles++;
        end
        assert (!wwl_any) else log_error("word line high at the end of a pass");
    endtask

    task automatic wait_for_row(int row);
        int cycles;
        cycles = 0;
        while (!j_wwl[row[ROW_IDX_W-1:0]]) begin
            if (cycles >= ROW_TIMEOUT) report_timeout("a J word line pulse mid-pass");
            next_cycle();
            cycles++;
        end
    endtask

    initial begin
        int errs;
        int cycles;
        rst          = 1'b1;
        en           = 1'b1;
        j_wr_en      = 1'b0;
        j_waddr      = '0;
        j_wdata      = '0;
        h_wr_en      = 1'b0;
        h_wdata      = '0;
        cfg_load     = 1'b0;
        timing       = '0;
        dt_cfg_start = 1'b0;
        monitor_on   = 1'b0;
        exp_high     = 1;
        exp_low      = 1;
        n_rows       = 0;
        exp_bypass   = 1'b0;
        error_count  = 0;
        test_count   = 0;
        void'($urandom(32'h69dc));
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;
        next_cycle();

        errs = error_count;
        assert (cfg_idle) else log_error("not idle after reset");
        assert (!wwl_any) else log_error("word line high after reset");
        assert (wbl == '0) else log_error("wbl not cleared by reset");
        finish_test("reset_idle", errs);

        for (int k = 0; k < NUM_SPIN; k++) begin
            j_rows[k] = random_row();
        end
        h_row = random_row();
        // corner codes 0, -8, -1 and +7
        j_rows[0][3:0] = {4'b0111, 4'b1111, 4'b1000, 4'b0000};
        h_row[3:0]     = {4'b0111, 4'b1111, 4'b1000, 4'b0000};
        write_store();
        monitor_on = 1'b1;

        errs = error_count;
        load_timing(3, 2, 4, 1'b0);
        run_pass("full converted pass");
        finish_test("full_pass", errs);

        errs = error_count;
        load_timing(1, 4, 2, 1'b0);
        run_pass("short pass");
        finish_test("short_pass_timing", errs);

        errs = error_count;
        load_timing(2, 1, 4, 1'b1);
        run_pass("bypass pass");
        finish_test("bypass_pass", errs);

        // drop en in the middle of a pass, then run a clean one
        errs = error_count;
        load_timing(3, 2, 4, 1'b0);
        next_cycle();
        dt_cfg_start = 1'b1;
        next_cycle();
        dt_cfg_start = 1'b0;
        wait_for_row(5);
        monitor_on = 1'b0;
        en = 1'b0;
        cycles = 0;
        while (!cfg_idle) begin
            if (cycles >= START_TIMEOUT) report_timeout("idle after dropping en");
            next_cycle();
            cycles++;
        end
        next_cycle();
        assert (cfg_idle && !wwl_any) else log_error("not quiet after abort");
        en = 1'b1;
        next_cycle();
        monitor_on = 1'b1;
        run_pass("pass after abort");
        finish_test("abort_restart", errs);

        $display("tests run: %0d, errors: %0d", test_count, error_count);
        if (error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- common/ising_pkg.sv
`default_nettype none

package ising_pkg;

    // array sizes, scaled down for simulation
    localparam int NUM_SPIN    = 16;
    localparam int BITDATA     = 4;
    localparam int PARALLELISM = 4;
    localparam int J_DEPTH     = NUM_SPIN / PARALLELISM;
    localparam int J_ADDR_W    = $clog2(J_DEPTH);
    localparam int CNT_W       = 16;

    // row select inside one stored J word, and the global row index
    localparam int ROW_SEL_W = $clog2(PARALLELISM);
    localparam int ROW_IDX_W = $clog2(NUM_SPIN);

    typedef logic signed [BITDATA-1:0] weight_t;
    typedef weight_t [NUM_SPIN-1:0] wbl_row_t;
    typedef wbl_row_t [PARALLELISM-1:0] j_word_t;

    typedef struct packed {
        logic [CNT_W-1:0]  wwl_high;
        logic [CNT_W-1:0]  wwl_low;
        logic [J_ADDR_W:0] trans_num;
        logic              bypass;
    } cfg_timing_t;

    typedef enum logic [2:0] {
        CFG_IDLE,
        CFG_FETCH,
        CFG_WWL_HIGH,
        CFG_WWL_LOW,
        CFG_NEXT
    } cfg_state_e;

    // two's complement weight to the macro's sign-magnitude code
    // bit 0 is the inverted sign, bits 3..1 the magnitude modulo 8
    function automatic weight_t to_analog(weight_t v);
        logic [BITDATA-2:0] mag;
        weight_t code;
        mag = v[BITDATA-2:0];
        if (v[BITDATA-1]) begin
            mag = -mag;
        end
        code = (v == '0) ? '0 : weight_t'({mag, ~v[BITDATA-1]});
        return code;
    endfunction

endpackage

`default_nettype wire

//--- design/ising_cfg_top.sv
`default_nettype none

module ising_cfg_top
    import ising_pkg::*;
(
    input  logic                clk_i,
    input  logic                rst_i,
    // host side
    input  logic                j_wr_en_i,
    input  logic [J_ADDR_W-1:0] j_waddr_i,
    input  j_word_t             j_wdata_i,
    input  logic                h_wr_en_i,
    input  wbl_row_t            h_wdata_i,
    input  logic                cfg_load_i,
    input  cfg_timing_t         timing_i,
    input  logic                en_i,
    input  logic                dt_cfg_start_i,
    // analog macro side
    output logic [NUM_SPIN-1:0] j_wwl_o,
    output logic                h_wwl_o,
    output wbl_row_t            wbl_o,
    output logic                cfg_idle_o
);

    logic                j_ren;
    logic                h_ren;
    logic [J_ADDR_W-1:0] j_raddr;
    j_word_t             j_rdata;
    wbl_row_t            h_rdata;

    weight_store i_weight_store (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .j_wr_en_i (j_wr_en_i),
        .j_waddr_i (j_waddr_i),
        .j_wdata_i (j_wdata_i),
        .h_wr_en_i (h_wr_en_i),
        .h_wdata_i (h_wdata_i),
        .j_ren_i   (j_ren),
        .j_raddr_i (j_raddr),
        .j_rdata_o (j_rdata),
        .h_ren_i   (h_ren),
        .h_rdata_o (h_rdata)
    );

    analog_cfg i_analog_cfg (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .en_i           (en_i),
        .cfg_load_i     (cfg_load_i),
        .timing_i       (timing_i),
        .dt_cfg_start_i (dt_cfg_start_i),
        .j_ren_o        (j_ren),
        .j_raddr_o      (j_raddr),
        .j_rdata_i      (j_rdata),
        .h_ren_o        (h_ren),
        .h_rdata_i      (h_rdata),
        .j_wwl_o        (j_wwl_o),
        .h_wwl_o        (h_wwl_o),
        .wbl_o          (wbl_o),
        .cfg_idle_o     (cfg_idle_o)
    );

endmodule

`default_nettype wire

//--- design/step_counter.sv
`default_nettype none

module step_counter
    import ising_pkg::*;
(
    input  logic             clk_i,
    input  logic             rst_i,
    input  logic             en_i,
    input  logic             load_i,
    input  logic             recount_i,
    input  logic             step_i,
    input  logic [CNT_W-1:0] d_i,
    output logic [CNT_W-1:0] q_o,
    output logic             maxed_o,
    output logic             overflow_o
);

    logic [CNT_W-1:0] limit_q;
    logic [CNT_W-1:0] count_q;

    // limit register, written by the host whether or not en_i is set
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            limit_q <= CNT_W'(1);
        end else if (load_i) begin
            limit_q <= d_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            count_q <= '0;
        end else if (load_i) begin
            count_q <= '0;
        end else if (en_i) begin
            if (recount_i) begin
                count_q <= '0;
            end else if (step_i) begin
                // wrap back to zero after limit steps
                count_q <= maxed_o ? '0 : count_q + CNT_W'(1);
            end
        end
    end

    assign q_o     = count_q;
    assign maxed_o = (count_q == limit_q - CNT_W'(1));

    // high in the same cycle as the step that wraps the count
    assign overflow_o = en_i & step_i & ~recount_i & ~load_i & maxed_o;

endmodule

`default_nettype wire

//--- design/weight_store.sv
`default_nettype none

module weight_store
    import ising_pkg::*;
(
    input  logic                clk_i,
    input  logic                rst_i,
    // host write side
    input  logic                j_wr_en_i,
    input  logic [J_ADDR_W-1:0] j_waddr_i,
    input  j_word_t             j_wdata_i,
    input  logic                h_wr_en_i,
    input  wbl_row_t            h_wdata_i,
    // writer read side
    input  logic                j_ren_i,
    input  logic [J_ADDR_W-1:0] j_raddr_i,
    output j_word_t             j_rdata_o,
    input  logic                h_ren_i,
    output wbl_row_t            h_rdata_o
);

    j_word_t  j_mem_q [J_DEPTH];
    wbl_row_t h_row_q;

    // J words, one per address, PARALLELISM rows each
    always_ff @(posedge clk_i) begin
        if (j_wr_en_i) begin
            j_mem_q[j_waddr_i] <= j_wdata_i;
        end
    end

    // the bias row is held on its own
    always_ff @(posedge clk_i) begin
        if (h_wr_en_i) begin
            h_row_q <= h_wdata_i;
        end
    end

    // registered reads, one cycle after the strobe
    // data holds between strobes so the writer can walk the rows of a word
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            j_rdata_o <= '0;
        end else if (j_ren_i) begin
            j_rdata_o <= j_mem_q[j_raddr_i];
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            h_rdata_o <= '0;
        end else if (h_ren_i) begin
            h_rdata_o <= h_row_q;
        end
    end

    // host writes and writer reads never overlap, since reads only happen
    // while a configuration pass is running
    host_write_idle_a: assert property (
        @(posedge clk_i) disable iff (rst_i)
        (j_wr_en_i || h_wr_en_i) |-> !(j_ren_i || h_ren_i)
    ) else $error("weight store written during a configuration pass");

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# build and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    --top-module tb_ising_cfg \
    -f src.f \
    -o tb_ising_cfg

./obj_dir/tb_ising_cfg > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failed" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
echo "simulation finished without a failure report"

//--- src.f
common/ising_pkg.sv
design/step_counter.sv
design/weight_store.sv
analog_cfg/wbl_converter.sv
analog_cfg/analog_cfg.sv
design/ising_cfg_top.sv
bench/tb_ising_cfg.sv
